/* include/result_config.svh */
`ifndef RESULT_CONFIG_SVH
`define RESULT_CONFIG_SVH

// APB bus widths
`define RES_ADDR_W        12
`define RES_DATA_W        32
`define RES_STRB_W        (`RES_DATA_W / 8)

// Data RAM from 0x000 to 0x3FF
`define RES_RAM_WORDS     256

// Answer table from 0x800 to 0x83F
`define RES_ANS_BASE      12'h800
`define RES_ANS_WORDS     16

// Test port
`define RES_PORT_ADDR     12'hFFC

// One run checks this many results
`define RES_CHECK_NUM     7
`define RES_BEGIN_SYMBOL  32'h00000168   // After byte swap

`endif

/* design/result_pkg.sv */
`include "result_config.svh"

package result_pkg;

	// Master to slave
	typedef struct packed {
		logic [`RES_ADDR_W-1:0] paddr;
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [`RES_DATA_W-1:0] pwdata;
		logic [`RES_STRB_W-1:0] pstrb;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		logic [`RES_DATA_W-1:0] prdata;
		logic                   pready;
		logic                   pslverr;
	} apb_rsp_t;

	// Result checker FSM
	typedef enum logic [1:0] {
		CHK_IDLE   = 2'd0,
		CHK_RUN    = 2'd1,
		CHK_REPORT = 2'd2
	} check_state_e;

	// Address map regions
	typedef enum logic [1:0] {
		REG_RAM  = 2'd0,
		REG_ANS  = 2'd1,
		REG_PORT = 2'd2,
		REG_NONE = 2'd3
	} region_e;

endpackage

/* design/apb_decoder.sv */
`timescale 1ns/100ps
`include "result_config.svh"

module apb_decoder (
	input  logic                clk,
	input  logic                rst,
	input  result_pkg::apb_req_t bus_req,
	output result_pkg::apb_rsp_t bus_rsp,
	output result_pkg::apb_req_t ram_req,
	output result_pkg::apb_req_t chk_req,
	input  result_pkg::apb_rsp_t ram_rsp,
	input  result_pkg::apb_rsp_t chk_rsp
);

	localparam logic [`RES_ADDR_W-1:0] RAM_TOP = `RES_ADDR_W'(`RES_RAM_WORDS * 4);
	localparam logic [`RES_ADDR_W-1:0] ANS_TOP = `RES_ADDR_W'(`RES_ANS_BASE + `RES_ANS_WORDS * 4);

	result_pkg::region_e region;
	result_pkg::region_e region_q;
	logic                pending;

	always_comb begin
		if (bus_req.paddr < RAM_TOP)
			region = result_pkg::REG_RAM;
		else if (bus_req.paddr >= `RES_ANS_BASE && bus_req.paddr < ANS_TOP)
			region = result_pkg::REG_ANS;
		else if (bus_req.paddr == `RES_PORT_ADDR)
			region = result_pkg::REG_PORT;
		else
			region = result_pkg::REG_NONE;
	end

	always_comb begin
		ram_req = bus_req;
		chk_req = bus_req;
		ram_req.psel = bus_req.psel && (region == result_pkg::REG_RAM);
		chk_req.psel = bus_req.psel && (region == result_pkg::REG_ANS ||
			region == result_pkg::REG_PORT);    // Checker splits these itself
	end

	// Latched in the setup cycle and held through wait states
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			region_q <= result_pkg::REG_NONE;
		else if (bus_req.psel && !bus_req.penable)
			region_q <= region;
	end

	always_comb begin
		bus_rsp = '0;
		case (region_q)
			result_pkg::REG_RAM: bus_rsp = ram_rsp;
			result_pkg::REG_ANS,
			result_pkg::REG_PORT: bus_rsp = chk_rsp;
			default: begin
				bus_rsp.pready  = bus_req.psel && bus_req.penable;
				bus_rsp.pslverr = bus_req.psel && bus_req.penable;    // Unmapped
			end
		endcase
	end

	assign pending = bus_req.psel && !(bus_req.penable && bus_rsp.pready);

	// Master keeps the request steady until the selected target completes it
	a_req_stable: assert property (@(posedge clk) disable iff (!rst)
		pending |=> bus_req.psel && $stable(bus_req.paddr));

endmodule

/* design/data_ram.sv */
`timescale 1ns/100ps
`include "result_config.svh"

module data_ram (
	input  logic                clk,
	input  logic                rst,
	input  result_pkg::apb_req_t req,
	output result_pkg::apb_rsp_t rsp
);

	localparam int RAM_AW = $clog2(`RES_RAM_WORDS);

	logic [`RES_DATA_W-1:0] mem [`RES_RAM_WORDS];
	logic [RAM_AW-1:0]      word_idx;
	logic                   access;
	logic                   wait_q;
	logic                   done;

	assign word_idx = req.paddr[RAM_AW+1:2];
	assign access   = req.psel && req.penable;
	assign done     = access && wait_q;

	// One wait state per transfer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			wait_q <= 1'b0;
		else if (done)
			wait_q <= 1'b0;
		else if (access)
			wait_q <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (done && req.pwrite) begin
			for (int b = 0; b < `RES_STRB_W; b++) begin
				if (req.pstrb[b])
					mem[word_idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
			end
		end
	end

	always_comb begin
		rsp.pready  = done;
		rsp.pslverr = 1'b0;
		if (req.psel && !req.pwrite)
			rsp.prdata = mem[word_idx];
		else
			rsp.prdata = '0;
	end

	// Completion only after a full access cycle with pready low
	a_wait_state: assert property (@(posedge clk) disable iff (!rst)
		rsp.pready |-> req.psel && req.penable &&
			$past(req.psel && req.penable && !rsp.pready));

endmodule

/* design/result_checker.sv */
`timescale 1ns/100ps
`include "result_config.svh"

module result_checker (
	input  logic                clk,
	input  logic                rst,
	input  result_pkg::apb_req_t req,
	output result_pkg::apb_rsp_t rsp,
	output logic [7:0]          error_count,
	output logic [15:0]         duration,
	output logic                finish
);

	localparam int ANS_AW = $clog2(`RES_ANS_WORDS);
	localparam logic [ANS_AW-1:0] LAST_IDX = ANS_AW'(`RES_CHECK_NUM - 1);

	logic [`RES_DATA_W-1:0]   ans_mem [`RES_ANS_WORDS];
	logic [ANS_AW-1:0]        ans_idx;
	logic [ANS_AW-1:0]        run_cnt;
	logic [`RES_DATA_W-1:0]   swapped;
	logic [`RES_DATA_W-1:0]   expected;
	logic [`RES_DATA_W-1:0]   status;
	logic                     is_port;
	logic                     done;
	logic                     port_wr;
	logic                     ans_wr;
	logic                     mismatch;
	result_pkg::check_state_e state_q;

	// Only ours when selected so anything but the port is the table
	assign is_port = (req.paddr == `RES_PORT_ADDR);
	assign ans_idx = req.paddr[ANS_AW+1:2];

	// No wait states
	assign done    = req.psel && req.penable;
	assign port_wr = done && req.pwrite && is_port;
	assign ans_wr  = done && req.pwrite && !is_port;

	// Little endian to readable order
	assign swapped = {req.pwdata[7:0], req.pwdata[15:8],
		req.pwdata[23:16], req.pwdata[31:24]};

	assign expected = ans_mem[run_cnt];
	assign mismatch = (swapped != expected);

	always_ff @(posedge clk) begin
		if (ans_wr) begin
			for (int b = 0; b < `RES_STRB_W; b++) begin
				if (req.pstrb[b])
					ans_mem[ans_idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q     <= result_pkg::CHK_IDLE;
			run_cnt     <= '0;
			error_count <= 8'd255;    // No run yet
			duration    <= '0;
		end else begin
			case (state_q)
				result_pkg::CHK_IDLE: begin
					if (port_wr && swapped == `RES_BEGIN_SYMBOL) begin
						state_q     <= result_pkg::CHK_RUN;
						run_cnt     <= '0;
						error_count <= '0;
						duration    <= '0;
					end
				end
				result_pkg::CHK_RUN: begin
					duration <= duration + 16'd1;
					if (port_wr) begin
						run_cnt <= run_cnt + 1'b1;
						if (mismatch && error_count != 8'd254)
							error_count <= error_count + 8'd1;
						if (run_cnt == LAST_IDX)
							state_q <= result_pkg::CHK_REPORT;
					end
				end
				default: begin
					// Frozen until reset and port writes dropped
					state_q <= state_q;
				end
			endcase
		end
	end

	assign finish = (state_q == result_pkg::CHK_REPORT);

	// Bit 31 finish, bits 9:8 state, bits 7:0 error count
	assign status = {finish, {(`RES_DATA_W - 11){1'b0}}, state_q, error_count};

	always_comb begin
		rsp.pready  = done;
		rsp.pslverr = 1'b0;
		if (req.psel && !req.pwrite)
			rsp.prdata = is_port ? status : ans_mem[ans_idx];
		else
			rsp.prdata = '0;
	end

	// Report only once every result of the run was counted
	a_finish_count: assert property (@(posedge clk) disable iff (!rst)
		finish |-> run_cnt == ANS_AW'(`RES_CHECK_NUM));

	a_err_valid: assert property (@(posedge clk) disable iff (!rst)
		state_q != result_pkg::CHK_IDLE |-> error_count != 8'd255);

endmodule

/* design/result_subsys.sv */
`timescale 1ns/100ps
`include "result_config.svh"

module result_subsys (
	input  logic                clk,
	input  logic                rst,
	input  result_pkg::apb_req_t bus_req,
	output result_pkg::apb_rsp_t bus_rsp,
	output logic [7:0]          error_count,
	output logic [15:0]         duration,
	output logic                finish
);

	result_pkg::apb_req_t ram_req;
	result_pkg::apb_req_t chk_req;
	result_pkg::apb_rsp_t ram_rsp;
	result_pkg::apb_rsp_t chk_rsp;

	apb_decoder decoder_i (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.ram_req (ram_req),
		.chk_req (chk_req),
		.ram_rsp (ram_rsp),
		.chk_rsp (chk_rsp)
	);

	// Program data, three cycles per transfer
	data_ram ram_i (
		.clk (clk),
		.rst (rst),
		.req (ram_req),
		.rsp (ram_rsp)
	);

	// Answer table and test port
	result_checker checker_i (
		.clk         (clk),
		.rst         (rst),
		.req         (chk_req),
		.rsp         (chk_rsp),
		.error_count (error_count),
		.duration    (duration),
		.finish      (finish)
	);

endmodule

/* tests/tb_result_subsys.sv */
`timescale 1ns/100ps
`include "result_config.svh"

module tb_result_subsys;

	// Worst-case transfers per test
	localparam int T1_XFERS = 32;
	localparam int T2_XFERS = 36;
	localparam int T3_XFERS = 4;
	localparam int T4_XFERS = 36;
	localparam int T5_XFERS = 37;
	localparam int T6_XFERS = 4;
	localparam int TIMEOUT_CYCLES =
		2 * (T1_XFERS + T2_XFERS + T3_XFERS + T4_XFERS + T5_XFERS + T6_XFERS) * 3;

	logic                 clk;
	logic                 rst;
	result_pkg::apb_req_t bus_req;
	result_pkg::apb_rsp_t bus_rsp;
	logic [7:0]           error_count;
	logic [15:0]          duration;
	logic                 finish;

	logic [15:0]            lfsr = 16'd38610;
	int                     cycle_cnt = 0;
	int                     done_cycle;
	int                     errors = 0;
	int                     checks = 0;
	int                     test_base;
	logic [`RES_DATA_W-1:0] ram_model [`RES_RAM_WORDS];
	logic [7:0]             ram_idx [8];    // Words already written once
	logic [`RES_DATA_W-1:0] ans_model [`RES_ANS_WORDS];

	result_subsys dut_i (
		.clk         (clk),
		.rst         (rst),
		.bus_req     (bus_req),
		.bus_rsp     (bus_rsp),
		.error_count (error_count),
		.duration    (duration),
		.finish      (finish)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("The run timed out after %0d cycles", cycle_cnt);
			$display("Some tests failed");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic rand_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], rand_bit()};
		return v;
	endfunction

	function automatic logic [31:0] swap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] m;
		m = old_w;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				m[b*8 +: 8] = new_w[b*8 +: 8];
		return m;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic do_reset();
		rst     = 1'b0;
		bus_req = '0;
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b1;
	endtask

	// One APB transfer as setup then access until pready
	task automatic apb_xfer(input logic wr, input logic [`RES_ADDR_W-1:0] addr,
		input logic [31:0] wdata, input logic [3:0] strb,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#2;
		bus_req.paddr   = addr;
		bus_req.psel    = 1'b1;
		bus_req.penable = 1'b0;
		bus_req.pwrite  = wr;
		bus_req.pwdata  = wdata;
		bus_req.pstrb   = strb;
		@(posedge clk);
		#2;
		bus_req.penable = 1'b1;
		@(negedge clk);
		while (!bus_rsp.pready)
			@(negedge clk);
		rdata      = bus_rsp.prdata;
		err        = bus_rsp.pslverr;
		done_cycle = cycle_cnt;    // Next edge completes
		@(posedge clk);
		#2;
		bus_req.psel    = 1'b0;
		bus_req.penable = 1'b0;
	endtask

	task automatic apb_write(input logic [`RES_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic err);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, strb, unused, err);
	endtask

	task automatic apb_read(input logic [`RES_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		apb_xfer(1'b0, addr, '0, 4'h0, data, err);
	endtask

	// Random strobed writes to words that hold known data
	task automatic ram_traffic(input int n);
		logic [7:0]  idx;
		logic [3:0]  strb;
		logic [31:0] d;
		logic        err;
		for (int i = 0; i < n; i++) begin
			idx  = ram_idx[rand_bits(3)];
			strb = 4'(rand_bits(4));
			d    = rand_bits(32);
			apb_write({2'b00, idx, 2'b00}, d, strb, err);
			ram_model[idx] = merge_bytes(ram_model[idx], d, strb);
			check_val("pslverr", err, 0);
		end
	endtask

	// Loads answers, starts a run and sends every result
	task automatic run_program(input logic corrupt, output int n_bad, output int edges);
		logic [31:0] d;
		logic        err;
		int          t_begin;
		n_bad = 0;
		for (int k = 0; k < `RES_CHECK_NUM; k++) begin
			ans_model[k] = rand_bits(32);
			apb_write(`RES_ANS_BASE + 12'(k * 4), ans_model[k], 4'hF, err);
		end
		apb_write(`RES_PORT_ADDR, swap32(`RES_BEGIN_SYMBOL), 4'hF, err);
		t_begin = done_cycle;
		for (int k = 0; k < `RES_CHECK_NUM; k++) begin
			ram_traffic(rand_bits(2));
			d = ans_model[k];
			if (corrupt && rand_bit()) begin
				d = d ^ ((rand_bits(31) << 1) | 32'h1);    // Low bit set so it always differs
				n_bad++;
			end
			apb_write(`RES_PORT_ADDR, swap32(d), 4'hF, err);
			check_val("pslverr", err, 0);
		end
		edges = done_cycle - t_begin;
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s finished with %0d errors", num, name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] rd;
		logic        err;
		int          n_bad;
		int          edges;
		rst       = 1'b0;
		bus_req   = '0;
		test_base = 0;
		do_reset();

		for (int i = 0; i < 8; i++) begin
			ram_idx[i] = 8'(rand_bits(8));
			d = rand_bits(32);
			apb_write({2'b00, ram_idx[i], 2'b00}, d, 4'hF, err);
			ram_model[ram_idx[i]] = d;
			check_val("pslverr", err, 0);
		end
		ram_traffic(16);
		for (int i = 0; i < 8; i++) begin
			apb_read({2'b00, ram_idx[i], 2'b00}, rd, err);
			check_val("prdata", rd, ram_model[ram_idx[i]]);
			check_val("pslverr", err, 0);
		end
		end_test(1, "ram");

		for (int i = 0; i < `RES_ANS_WORDS; i++) begin
			ans_model[i] = rand_bits(32);
			apb_write(`RES_ANS_BASE + 12'(i * 4), ans_model[i], 4'hF, err);
			check_val("pslverr", err, 0);
		end
		for (int i = 0; i < `RES_ANS_WORDS; i++) begin
			apb_read(`RES_ANS_BASE + 12'(i * 4), rd, err);
			check_val("prdata", rd, ans_model[i]);
		end
		apb_read(12'h400, rd, err);    // Gap above RAM
		check_val("pslverr", err, 1);
		check_val("prdata", rd, 0);
		apb_read(12'h900, rd, err);
		check_val("pslverr", err, 1);
		check_val("prdata", rd, 0);
		apb_read(12'hFF8, rd, err);
		check_val("pslverr", err, 1);
		check_val("prdata", rd, 0);
		apb_write(12'h7FC, rand_bits(32), 4'hF, err);
		check_val("pslverr", err, 1);
		end_test(2, "answer table");

		do_reset();
		check_val("error_count", error_count, 8'hFF);
		check_val("finish", finish, 0);
		check_val("duration", duration, 0);
		check_val("pready", bus_rsp.pready, 0);
		check_val("pslverr", bus_rsp.pslverr, 0);
		for (int i = 0; i < 3; i++) begin
			d = rand_bits(32);
			if (swap32(d) == `RES_BEGIN_SYMBOL)
				d = d ^ 32'h1;
			apb_write(`RES_PORT_ADDR, d, 4'hF, err);
		end
		check_val("error_count", error_count, 8'hFF);
		check_val("finish", finish, 0);
		apb_read(`RES_PORT_ADDR, rd, err);
		check_val("status", rd, 32'h0000_00FF);
		end_test(3, "idle port");

		run_program(1'b0, n_bad, edges);
		check_val("finish", finish, 1);
		check_val("error_count", error_count, 0);
		check_val("duration", duration, edges);
		end_test(4, "pass run");

		do_reset();
		run_program(1'b1, n_bad, edges);
		check_val("finish", finish, 1);
		check_val("error_count", error_count, n_bad);
		check_val("duration", duration, edges);
		apb_read(`RES_PORT_ADDR, rd, err);
		check_val("status", rd, {1'b1, 21'd0, result_pkg::CHK_REPORT, 8'(n_bad)});
		end_test(5, "error run");

		apb_write(`RES_PORT_ADDR, swap32(`RES_BEGIN_SYMBOL), 4'hF, err);
		apb_write(`RES_PORT_ADDR, rand_bits(32), 4'hF, err);
		apb_write(`RES_PORT_ADDR, rand_bits(32), 4'hF, err);
		check_val("error_count", error_count, n_bad);
		check_val("duration", duration, edges);
		check_val("finish", finish, 1);
		end_test(6, "after finish");

		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
design/result_pkg.sv
design/apb_decoder.sv
design/data_ram.sv
design/result_checker.sv
design/result_subsys.sv
tests/tb_result_subsys.sv

/* Bender.yml */
package:
  name: result_subsys

export_include_dirs:
  - include

sources:
  # Package first, then leaf modules, then the top level
  - design/result_pkg.sv
  - design/apb_decoder.sv
  - design/data_ram.sv
  - design/result_checker.sv
  - design/result_subsys.sv

  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_result_subsys.sv
